// ==== flist.f ====
hdl/id_read_pkg.sv
hdl/id_sample_timer.sv
hdl/id_debounce.sv
hdl/id_field_decode.sv
hdl/id_result_reg.sv
hdl/id_read_top.sv
sim/id_read_checker.sv
sim/tb_id_read.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ID reader testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module tb_id_read \
    -f flist.f \
    -o sim_id_read

output=$(./obj_dir/sim_id_read 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "PASS: all tests"; then
    exit 0
fi
exit 1

// ==== sim/tb_id_read.sv ====
// Board position ID reader testbench
`timescale 1ns/10ps
`default_nettype none

module tb_id_read import id_read_pkg::*; ();

    localparam int TICK_CLKS        = 5;
    localparam int TICKS_PER_SAMPLE = 2;
    localparam int STABLE_COUNT     = 3;
    localparam int TIMEOUT_SAMPLES  = 20;
    localparam bit CHK_ENABLE       = 1'b1;
    localparam int SAMPLE_CLKS      = TICK_CLKS * TICKS_PER_SAMPLE;
    // boot 1, random 8, parity 3, timeout 1, stall 3, rescan 1
    localparam int NUM_READS        = 17;
    // Longer than a whole stable read, so a stray read shows its record
    localparam int IDLE_WAIT        = (STABLE_COUNT + 2) * SAMPLE_CLKS + 10;
    localparam int CYCLE_LIMIT      = NUM_READS * (TIMEOUT_SAMPLES + 2) * SAMPLE_CLKS + 1000;

    logic         clk;
    logic         rst_n;
    station_raw_t i_station;
    rack_raw_t    i_rack;
    slot_raw_t    i_slot;
    logic         i_rescan;
    logic         o_id_valid;
    id_status_e   o_status;
    station_id_t  o_station_id;
    rack_id_t     o_rack_id;
    slot_id_t     o_slot_id;
    logic         o_station_err;
    logic         o_rack_err;
    logic         o_slot_err;
    logic         i_id_ready;

    // Expected record of the read in flight
    string        test_name = "reset";
    id_status_e   exp_status;
    station_id_t  exp_station;
    rack_id_t     exp_rack;
    slot_id_t     exp_slot;
    logic         exp_station_err;
    logic         exp_rack_err;
    logic         exp_slot_err;
    int           rec_cnt = 0;
    int           cycle_cnt = 0;
    int           seed = 21760;
    bit           verdict_done = 1'b0;

    id_read_top #(
        .TICK_CLKS        (TICK_CLKS),
        .TICKS_PER_SAMPLE (TICKS_PER_SAMPLE),
        .STABLE_COUNT     (STABLE_COUNT),
        .TIMEOUT_SAMPLES  (TIMEOUT_SAMPLES),
        .CHK_ENABLE       (CHK_ENABLE)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_station     (i_station),
        .i_rack        (i_rack),
        .i_slot        (i_slot),
        .i_rescan      (i_rescan),
        .o_id_valid    (o_id_valid),
        .o_status      (o_status),
        .o_station_id  (o_station_id),
        .o_rack_id     (o_rack_id),
        .o_slot_id     (o_slot_id),
        .o_station_err (o_station_err),
        .o_rack_err    (o_rack_err),
        .o_slot_err    (o_slot_err),
        .i_id_ready    (i_id_ready)
    );

    bind id_result_reg id_read_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_arm         (o_arm),
        .i_dec_valid   (i_valid),
        .i_id_valid    (o_id_valid),
        .i_id_ready    (i_id_ready),
        .i_status      (o_status),
        .i_station_id  (o_station_id),
        .i_rack_id     (o_rack_id),
        .i_slot_id     (o_slot_id),
        .i_station_err (o_station_err),
        .i_rack_err    (o_rack_err),
        .i_slot_err    (o_slot_err)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////

    // Expected record from the applied straps
    function automatic void ref_model(
        input  bit           never_stable,
        input  station_raw_t st,
        input  rack_raw_t    rk,
        input  slot_raw_t    sl,
        output id_status_e   status,
        output station_id_t  st_id,
        output rack_id_t     rk_id,
        output slot_id_t     sl_id,
        output logic         st_err,
        output logic         rk_err,
        output logic         sl_err
    );
        if (never_stable)
        begin
            status = ID_TIMEOUT;
            st_id  = '0;
            rk_id  = '0;
            sl_id  = '0;
            st_err = 1'b1;
            rk_err = 1'b1;
            sl_err = 1'b1;
        end
        else
        begin
            // Even parity over each whole raw field
            st_err = (^st) && CHK_ENABLE;
            rk_err = (^rk) && CHK_ENABLE;
            sl_err = (^sl) && CHK_ENABLE;
            st_id  = st[6:0];
            rk_id  = rk[2:0];
            sl_id  = sl[3:0];
            if (st_err || rk_err || sl_err)
                status = ID_PARITY_ERR;
            else
                status = ID_OK;
        end
    endfunction

    task automatic stop_run();
        verdict_done = 1'b1;
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_status(input string name, input id_status_e exp, input id_status_e act);
        if (act !== exp)
        begin
            $display("** Error [%s] status: expected %0d, actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_station(input string name, input station_id_t exp,
                                 input station_id_t act);
        if (act !== exp)
        begin
            $display("** Error [%s] station: expected 0x%0h, actual 0x%0h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_rack(input string name, input rack_id_t exp, input rack_id_t act);
        if (act !== exp)
        begin
            $display("** Error [%s] rack: expected 0x%0h, actual 0x%0h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_slot(input string name, input slot_id_t exp, input slot_id_t act);
        if (act !== exp)
        begin
            $display("** Error [%s] slot: expected 0x%0h, actual 0x%0h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error [%s]: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // Every transfer at the output is compared with the reference
    always @(posedge clk)
    begin
        if (rst_n && o_id_valid && i_id_ready)
        begin
            check_status(test_name, exp_status, o_status);
            check_station(test_name, exp_station, o_station_id);
            check_rack(test_name, exp_rack, o_rack_id);
            check_slot(test_name, exp_slot, o_slot_id);
            check_err({test_name, " station_err"}, exp_station_err, o_station_err);
            check_err({test_name, " rack_err"}, exp_rack_err, o_rack_err);
            check_err({test_name, " slot_err"}, exp_slot_err, o_slot_err);
            rec_cnt = rec_cnt + 1;
        end
    end

    // Run length guard
    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT)
        begin
            $display("Timeout: no verdict after %0d cycles, last test %s", CYCLE_LIMIT,
                     test_name);
            stop_run();
        end
    end

    // A failed assertion can end the run without a verdict line
    final
    begin
        if (!verdict_done)
            $display("FAIL: see errors above");
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Random straps with correct even parity in every field
    task automatic draw_straps(output station_raw_t st, output rack_raw_t rk,
                               output slot_raw_t sl);
        logic [31:0] r;

        r  = $random(seed);
        st = {^r[6:0], r[6:0]};
        rk = {^r[9:7], r[9:7]};
        sl = {^r[13:10], r[13:10]};
    endtask

    // One complete read, from strap setup to the idle gap after the transfer
    task automatic read_once(
        input string        name,
        input station_raw_t st,
        input rack_raw_t    rk,
        input slot_raw_t    sl,
        input bit           use_rescan,
        input bit           never_stable,
        input int           hold,
        input bit           mid_rescan
    );
        int                 waited;
        int                 k;
        int                 exp_cnt;
        logic [STRAP_W-1:0] churn;
        id_status_e         snap_status;
        station_id_t        snap_station;
        rack_id_t           snap_rack;
        slot_id_t           snap_slot;
        logic               snap_st_err;
        logic               snap_rk_err;
        logic               snap_sl_err;

        test_name = name;
        ref_model(never_stable, st, rk, sl, exp_status, exp_station, exp_rack, exp_slot,
                  exp_station_err, exp_rack_err, exp_slot_err);
        exp_cnt    = rec_cnt + 1;
        i_station  = st;
        i_rack     = rk;
        i_slot     = sl;
        i_id_ready = (hold == 0);
        churn      = {st, rk, sl};

        // One cycle rescan request
        if (use_rescan)
        begin
            @(negedge clk);
            i_rescan = 1'b1;
        end

        // Unstable straps step on every clock so no two samples match
        waited = 0;
        while (!o_id_valid)
        begin
            @(negedge clk);
            waited = waited + 1;
            i_rescan = mid_rescan && (waited == 20);
            if (never_stable)
            begin
                churn = churn + 1'b1;
                {i_station, i_rack, i_slot} = churn;
            end
        end
        i_rescan = 1'b0;

        // Consumer stall, record must not move
        if (hold > 0)
        begin
            snap_status  = o_status;
            snap_station = o_station_id;
            snap_rack    = o_rack_id;
            snap_slot    = o_slot_id;
            snap_st_err  = o_station_err;
            snap_rk_err  = o_rack_err;
            snap_sl_err  = o_slot_err;
            for (k = 0; k < hold; k++)
            begin
                @(negedge clk);
                i_rescan = mid_rescan && (k == 0);
                if (!o_id_valid)
                begin
                    $display("%s: result valid dropped while the consumer stalled", name);
                    stop_run();
                end
                check_status({name, " stall"}, snap_status, o_status);
                check_station({name, " stall"}, snap_station, o_station_id);
                check_rack({name, " stall"}, snap_rack, o_rack_id);
                check_slot({name, " stall"}, snap_slot, o_slot_id);
                check_err({name, " stall station_err"}, snap_st_err, o_station_err);
                check_err({name, " stall rack_err"}, snap_rk_err, o_rack_err);
                check_err({name, " stall slot_err"}, snap_sl_err, o_slot_err);
            end
            i_rescan   = 1'b0;
            i_id_ready = 1'b1;
        end

        // Transfer on the next rising edge, then nothing more
        @(negedge clk);
        repeat (IDLE_WAIT)
        begin
            if (o_id_valid)
            begin
                $display("%s: an extra record appeared after the transfer", name);
                stop_run();
            end
            @(negedge clk);
        end
        if (rec_cnt != exp_cnt)
        begin
            $display("%s: %0d records delivered so far, %0d expected", name, rec_cnt, exp_cnt);
            stop_run();
        end
    endtask

    initial
    begin
        int           i;
        logic [31:0]  r;
        station_raw_t st;
        rack_raw_t    rk;
        slot_raw_t    sl;

        rst_n      = 1'b0;
        i_rescan   = 1'b0;
        i_id_ready = 1'b1;
        st         = {^7'h2A, 7'h2A};
        rk         = {^3'h5, 3'h5};
        sl         = {^4'h9, 4'h9};
        i_station  = st;
        i_rack     = rk;
        i_slot     = sl;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // First read starts by itself after reset
        read_once("boot", st, rk, sl, 1'b0, 1'b0, 0, 1'b0);

        for (i = 0; i < 8; i++)
        begin
            draw_straps(st, rk, sl);
            read_once($sformatf("random_%0d", i), st, rk, sl, 1'b1, 1'b0, 0, 1'b0);
        end

        // Parity bit flipped in exactly one field
        draw_straps(st, rk, sl);
        read_once("parity_station", st ^ 8'h80, rk, sl, 1'b1, 1'b0, 0, 1'b0);
        draw_straps(st, rk, sl);
        read_once("parity_rack", st, rk ^ 4'h8, sl, 1'b1, 1'b0, 0, 1'b0);
        draw_straps(st, rk, sl);
        read_once("parity_slot", st, rk, sl ^ 5'h10, 1'b1, 1'b0, 0, 1'b0);

        draw_straps(st, rk, sl);
        read_once("timeout", st, rk, sl, 1'b1, 1'b1, 0, 1'b0);

        for (i = 0; i < 3; i++)
        begin
            draw_straps(st, rk, sl);
            r = $random(seed);
            read_once($sformatf("stall_%0d", i), st, rk, sl, 1'b1, 1'b0,
                      1 + int'(r[4:0]), 1'b0);
        end

        // Extra requests while armed and while held
        draw_straps(st, rk, sl);
        read_once("rescan_ignored", st, rk, sl, 1'b1, 1'b0, 5, 1'b1);

        if (rec_cnt == NUM_READS)
        begin
            verdict_done = 1'b1;
            $display("PASS: all tests");
            $finish;
        end
        else
        begin
            $display("Run delivered %0d records, %0d expected", rec_cnt, NUM_READS);
            stop_run();
        end
    end

endmodule

`default_nettype wire

// ==== sim/id_read_checker.sv ====
// Result handshake assertions
`timescale 1ns/10ps
`default_nettype none

module id_read_checker import id_read_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_arm,
    input  logic        i_dec_valid,
    input  logic        i_id_valid,
    input  logic        i_id_ready,
    input  id_status_e  i_status,
    input  station_id_t i_station_id,
    input  rack_id_t    i_rack_id,
    input  slot_id_t    i_slot_id,
    input  logic        i_station_err,
    input  logic        i_rack_err,
    input  logic        i_slot_err
);

    // Record stays up and unchanged while the consumer stalls
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        i_id_valid && !i_id_ready |=> i_id_valid && $stable({i_status, i_station_id,
            i_rack_id, i_slot_id, i_station_err, i_rack_err, i_slot_err}))
        else $error("result record dropped or changed before its transfer");

    // A new read starts only once the decode stage has drained
    a_arm_excl: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_arm) |-> !i_dec_valid)
        else $error("read armed while a decoded record is still pending");

    // Timeout carries no usable ID
    a_timeout_zero: assert property (@(posedge clk) disable iff (!rst_n)
        i_id_valid && (i_status == ID_TIMEOUT) |->
            (i_station_id == '0) && (i_rack_id == '0) && (i_slot_id == '0))
        else $error("timeout record with nonzero ID fields");

endmodule

`default_nettype wire

// ==== hdl/id_read_top.sv ====
// Board position ID reader
`timescale 1ns/10ps
`default_nettype none

module id_read_top import id_read_pkg::*; #(
    parameter int TICK_CLKS        = 50000,
    parameter int TICKS_PER_SAMPLE = 10,
    parameter int STABLE_COUNT     = 3,
    parameter int TIMEOUT_SAMPLES  = 100,
    parameter bit CHK_ENABLE       = 1'b1
) (
    input  logic         clk,
    input  logic         rst_n,
    input  station_raw_t i_station,
    input  rack_raw_t    i_rack,
    input  slot_raw_t    i_slot,
    input  logic         i_rescan,
    output logic         o_id_valid,
    output id_status_e   o_status,
    output station_id_t  o_station_id,
    output rack_id_t     o_rack_id,
    output slot_id_t     o_slot_id,
    output logic         o_station_err,
    output logic         o_rack_err,
    output logic         o_slot_err,
    input  logic         i_id_ready
);

    // Read control
    logic         arm;
    logic         sample_pulse;

    // Debounce to decode
    logic         dbc_valid;
    logic         dbc_ready;
    logic         dbc_timeout;
    station_raw_t dbc_station;
    rack_raw_t    dbc_rack;
    slot_raw_t    dbc_slot;

    // Decode to result
    logic         dec_valid;
    logic         dec_ready;
    id_status_e   dec_status;
    station_id_t  dec_station_id;
    rack_id_t     dec_rack_id;
    slot_id_t     dec_slot_id;
    logic         dec_station_err;
    logic         dec_rack_err;
    logic         dec_slot_err;

    ////////////////////////////////////////
    // Stage instances
    ////////////////////////////////////////

    id_sample_timer #(
        .TICK_CLKS        (TICK_CLKS),
        .TICKS_PER_SAMPLE (TICKS_PER_SAMPLE)
    ) u_timer (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_arm          (arm),
        .o_sample_pulse (sample_pulse)
    );

    id_debounce #(
        .STABLE_COUNT    (STABLE_COUNT),
        .TIMEOUT_SAMPLES (TIMEOUT_SAMPLES)
    ) u_debounce (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_arm          (arm),
        .i_sample_pulse (sample_pulse),
        .i_station      (i_station),
        .i_rack         (i_rack),
        .i_slot         (i_slot),
        .o_valid        (dbc_valid),
        .o_timeout      (dbc_timeout),
        .o_station      (dbc_station),
        .o_rack         (dbc_rack),
        .o_slot         (dbc_slot),
        .i_ready        (dbc_ready)
    );

    id_field_decode #(
        .CHK_ENABLE (CHK_ENABLE)
    ) u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_valid       (dbc_valid),
        .o_ready       (dbc_ready),
        .i_timeout     (dbc_timeout),
        .i_station     (dbc_station),
        .i_rack        (dbc_rack),
        .i_slot        (dbc_slot),
        .o_valid       (dec_valid),
        .o_status      (dec_status),
        .o_station_id  (dec_station_id),
        .o_rack_id     (dec_rack_id),
        .o_slot_id     (dec_slot_id),
        .o_station_err (dec_station_err),
        .o_rack_err    (dec_rack_err),
        .o_slot_err    (dec_slot_err),
        .i_ready       (dec_ready)
    );

    id_result_reg u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_rescan      (i_rescan),
        .o_arm         (arm),
        .i_valid       (dec_valid),
        .o_ready       (dec_ready),
        .i_status      (dec_status),
        .i_station_id  (dec_station_id),
        .i_rack_id     (dec_rack_id),
        .i_slot_id     (dec_slot_id),
        .i_station_err (dec_station_err),
        .i_rack_err    (dec_rack_err),
        .i_slot_err    (dec_slot_err),
        .o_id_valid    (o_id_valid),
        .o_status      (o_status),
        .o_station_id  (o_station_id),
        .o_rack_id     (o_rack_id),
        .o_slot_id     (o_slot_id),
        .o_station_err (o_station_err),
        .o_rack_err    (o_rack_err),
        .o_slot_err    (o_slot_err),
        .i_id_ready    (i_id_ready)
    );

endmodule

`default_nettype wire

// ==== hdl/id_result_reg.sv ====
// ID result hold and read control
`timescale 1ns/10ps
`default_nettype none

module id_result_reg import id_read_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_rescan,
    output logic        o_arm,
    input  logic        i_valid,
    output logic        o_ready,
    input  id_status_e  i_status,
    input  station_id_t i_station_id,
    input  rack_id_t    i_rack_id,
    input  slot_id_t    i_slot_id,
    input  logic        i_station_err,
    input  logic        i_rack_err,
    input  logic        i_slot_err,
    output logic        o_id_valid,
    output id_status_e  o_status,
    output station_id_t o_station_id,
    output rack_id_t    o_rack_id,
    output slot_id_t    o_slot_id,
    output logic        o_station_err,
    output logic        o_rack_err,
    output logic        o_slot_err,
    input  logic        i_id_ready
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ARMED = 2'd1,
        HOLD  = 2'd2
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   boot_req;
    logic   take;

    // Read in flight, accept the one record it produces
    assign o_arm      = (state == ARMED);
    assign o_ready    = (state == ARMED);
    assign o_id_valid = (state == HOLD);
    assign take       = i_valid && o_ready;

    ////////////////////////////////////////
    // Read control FSM
    ////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            // Rescan only counts here, nothing armed or pending
            IDLE:    if (boot_req || i_rescan) state_nxt = ARMED;
            ARMED:   if (take) state_nxt = HOLD;
            HOLD:    if (i_id_ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Boot request starts the first read one cycle after reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= IDLE;
            boot_req <= 1'b1;
        end
        else
        begin
            state <= state_nxt;
            if (state_nxt == ARMED)
                boot_req <= 1'b0;
        end
    end

    // Result record, stable for as long as HOLD lasts
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            o_status      <= i_status;
            o_station_id  <= i_station_id;
            o_rack_id     <= i_rack_id;
            o_slot_id     <= i_slot_id;
            o_station_err <= i_station_err;
            o_rack_err    <= i_rack_err;
            o_slot_err    <= i_slot_err;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/id_field_decode.sv ====
// ID field parity decode
`timescale 1ns/10ps
`default_nettype none

module id_field_decode import id_read_pkg::*; #(
    parameter bit CHK_ENABLE = 1'b1
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         i_valid,
    output logic         o_ready,
    input  logic         i_timeout,
    input  station_raw_t i_station,
    input  rack_raw_t    i_rack,
    input  slot_raw_t    i_slot,
    output logic         o_valid,
    output id_status_e   o_status,
    output station_id_t  o_station_id,
    output rack_id_t     o_rack_id,
    output slot_id_t     o_slot_id,
    output logic         o_station_err,
    output logic         o_rack_err,
    output logic         o_slot_err,
    input  logic         i_ready
);

    logic       load;
    logic       st_par;
    logic       rk_par;
    logic       sl_par;
    id_status_e status_nxt;

    // One entry, accepts when empty or draining this cycle
    assign o_ready = !o_valid || i_ready;
    assign load    = i_valid && o_ready;

    // Even parity per field, odd XOR flags an error
    assign st_par = CHK_ENABLE & (^i_station);
    assign rk_par = CHK_ENABLE & (^i_rack);
    assign sl_par = CHK_ENABLE & (^i_slot);

    // Timeout overrides any parity result
    always_comb
    begin
        if (i_timeout)
            status_nxt = ID_TIMEOUT;
        else if (st_par || rk_par || sl_par)
            status_nxt = ID_PARITY_ERR;
        else
            status_nxt = ID_OK;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_valid <= 1'b0;
        else if (load)
            o_valid <= 1'b1;
        else if (i_ready)
            o_valid <= 1'b0;
    end

    // Record register
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            o_status <= status_nxt;
            if (i_timeout)
            begin
                // No usable straps, zero IDs and flag every field
                o_station_id  <= '0;
                o_rack_id     <= '0;
                o_slot_id     <= '0;
                o_station_err <= 1'b1;
                o_rack_err    <= 1'b1;
                o_slot_err    <= 1'b1;
            end
            else
            begin
                // Parity bit sits on top, keep the rest
                o_station_id  <= i_station[STATION_W-2:0];
                o_rack_id     <= i_rack[RACK_W-2:0];
                o_slot_id     <= i_slot[SLOT_W-2:0];
                o_station_err <= st_par;
                o_rack_err    <= rk_par;
                o_slot_err    <= sl_par;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/id_debounce.sv ====
// Strap debounce and timeout
`timescale 1ns/10ps
`default_nettype none

module id_debounce import id_read_pkg::*; #(
    parameter int STABLE_COUNT    = 3,
    parameter int TIMEOUT_SAMPLES = 100
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         i_arm,
    input  logic         i_sample_pulse,
    input  station_raw_t i_station,
    input  rack_raw_t    i_rack,
    input  slot_raw_t    i_slot,
    output logic         o_valid,
    output logic         o_timeout,
    output station_raw_t o_station,
    output rack_raw_t    o_rack,
    output slot_raw_t    o_slot,
    input  logic         i_ready
);

    localparam int MATCH_W = $clog2(STABLE_COUNT + 1);
    localparam int SAMP_W  = $clog2(TIMEOUT_SAMPLES + 1);
    localparam logic [MATCH_W-1:0] MATCH_LAST = MATCH_W'(STABLE_COUNT - 1);
    localparam logic [SAMP_W-1:0]  SAMP_LAST  = SAMP_W'(TIMEOUT_SAMPLES - 1);

    ////////////////////////////////////////
    // Strap synchronizer
    ////////////////////////////////////////

    logic [STRAP_W-1:0] strap_meta;
    logic [STRAP_W-1:0] strap_sync;

    // Two flops, straps are quasi-static
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            strap_meta <= '0;
            strap_sync <= '0;
        end
        else
        begin
            strap_meta <= {i_station, i_rack, i_slot};
            strap_sync <= strap_meta;
        end
    end

    ////////////////////////////////////////
    // Sample compare and counters
    ////////////////////////////////////////

    logic [STRAP_W-1:0] strap_prev;
    logic [STRAP_W-1:0] rec;
    logic               have_prev;
    logic               rd_done;
    logic [MATCH_W-1:0] match_cnt;
    logic [SAMP_W-1:0]  samp_cnt;
    logic               take_sample;
    logic               same;
    logic               stable_hit;
    logic               timeout_hit;
    logic               emit;

    // Samples are ignored once this read has produced its record
    assign take_sample = i_arm && i_sample_pulse && !rd_done;

    // First sample has nothing to compare against
    assign same        = have_prev && (strap_sync == strap_prev);
    assign stable_hit  = same && (match_cnt == MATCH_LAST);
    // This sample brings the total to the limit
    assign timeout_hit = (samp_cnt == SAMP_LAST);
    assign emit        = take_sample && (stable_hit || timeout_hit);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            have_prev <= 1'b0;
            rd_done   <= 1'b0;
            match_cnt <= '0;
            samp_cnt  <= '0;
        end
        else if (!i_arm)
        begin
            // Fresh start for the next read
            have_prev <= 1'b0;
            rd_done   <= 1'b0;
            match_cnt <= '0;
            samp_cnt  <= '0;
        end
        else if (take_sample)
        begin
            have_prev <= 1'b1;
            samp_cnt  <= samp_cnt + 1'b1;
            match_cnt <= same ? match_cnt + 1'b1 : '0;
            if (stable_hit || timeout_hit)
                rd_done <= 1'b1;
        end
    end

    // Previous sample and the delivered record
    always_ff @(posedge clk)
    begin
        if (take_sample)
            strap_prev <= strap_sync;
        if (emit)
            rec <= strap_sync;
    end

    ////////////////////////////////////////
    // Output handshake
    ////////////////////////////////////////

    // Valid holds until the decode stage takes it, even after arm drops
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_valid   <= 1'b0;
            o_timeout <= 1'b0;
        end
        else if (emit)
        begin
            o_valid   <= 1'b1;
            o_timeout <= !stable_hit;   // stability wins on a tie
        end
        else if (i_ready)
            o_valid <= 1'b0;
    end

    assign {o_station, o_rack, o_slot} = rec;

endmodule

`default_nettype wire

// ==== hdl/id_sample_timer.sv ====
// Strap sample interval timer
`timescale 1ns/10ps
`default_nettype none

module id_sample_timer #(
    parameter int TICK_CLKS        = 50000,
    parameter int TICKS_PER_SAMPLE = 10
) (
    input  logic clk,
    input  logic rst_n,
    input  logic i_arm,
    output logic o_sample_pulse
);

    // Counter widths, at least one bit each
    localparam int TICK_W = (TICK_CLKS > 1) ? $clog2(TICK_CLKS) : 1;
    localparam int SPAN_W = (TICKS_PER_SAMPLE > 1) ? $clog2(TICKS_PER_SAMPLE) : 1;
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICK_CLKS - 1);
    localparam logic [SPAN_W-1:0] SPAN_LAST = SPAN_W'(TICKS_PER_SAMPLE - 1);

    logic [TICK_W-1:0] tick_cnt;
    logic [SPAN_W-1:0] span_cnt;
    logic              tick_end;

    // Last clock of a base tick
    assign tick_end = (tick_cnt == TICK_LAST);

    // Base tick divider, then ticks per sample
    // Both restart from zero whenever arm is low
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tick_cnt <= '0;
            span_cnt <= '0;
        end
        else if (!i_arm)
        begin
            tick_cnt <= '0;
            span_cnt <= '0;
        end
        else
        begin
            tick_cnt <= tick_end ? '0 : tick_cnt + 1'b1;
            if (tick_end)
                span_cnt <= (span_cnt == SPAN_LAST) ? '0 : span_cnt + 1'b1;
        end
    end

    // One clock wide, only while a read is armed
    assign o_sample_pulse = i_arm && tick_end && (span_cnt == SPAN_LAST);

endmodule

`default_nettype wire

// ==== hdl/id_read_pkg.sv ====
// Board position ID types
`default_nettype none

package id_read_pkg;

    ////////////////////////////////////////
    // Strap field widths
    ////////////////////////////////////////

    // Raw widths include the parity bit in the top position
    localparam int STATION_W = 8;
    localparam int RACK_W    = 4;
    localparam int SLOT_W    = 5;

    // All straps side by side, station in the upper bits
    localparam int STRAP_W   = STATION_W + RACK_W + SLOT_W;

    ////////////////////////////////////////
    // Raw and decoded fields
    ////////////////////////////////////////

    // Raw strap fields as seen on the backplane pins
    typedef logic [STATION_W-1:0] station_raw_t;
    typedef logic [RACK_W-1:0]    rack_raw_t;
    typedef logic [SLOT_W-1:0]    slot_raw_t;

    // Decoded IDs with the parity bit removed
    typedef logic [STATION_W-2:0] station_id_t;
    typedef logic [RACK_W-2:0]    rack_id_t;
    typedef logic [SLOT_W-2:0]    slot_id_t;

    // How a read ended
    typedef enum logic [1:0] {
        ID_OK         = 2'd0,
        ID_PARITY_ERR = 2'd1,
        ID_TIMEOUT    = 2'd2
    } id_status_e;

endpackage

`default_nettype wire
